/* verilog/blackjack_consts.svh */
`ifndef BLACKJACK_CONSTS_SVH
`define BLACKJACK_CONSTS_SVH

// ----------------------------------------------------------------------
// widths
// ----------------------------------------------------------------------
`define BJ_CARD_W 4
`define BJ_SCORE_W 6
`define BJ_COIN_W 8
`define BJ_BET_W 4

// ----------------------------------------------------------------------
// game rules
// ----------------------------------------------------------------------
`define BJ_TARGET 21
`define BJ_DEALER_STAND 17
// extra worth of one ace counted high
`define BJ_ACE_BONUS 10
`define BJ_INITIAL_COINS 100
`define BJ_MAX_COINS 255

// card source
`define BJ_LFSR_W 16
`define BJ_LFSR_SEED 16'hACE1

`endif

/* verilog/blackjack_pkg.sv */
`include "blackjack_consts.svh"

package blackjack_pkg;

    // card value 1 to 10, ace is 1, face cards are 10
    typedef logic [`BJ_CARD_W-1:0] card_t;

    typedef logic [`BJ_SCORE_W-1:0] score_t;

    typedef logic [`BJ_COIN_W-1:0] coin_t;

    typedef logic [`BJ_BET_W-1:0] bet_t;

    typedef enum logic [1:0] {
        OUTCOME_LOSE,
        OUTCOME_DRAW,
        OUTCOME_WIN,
        OUTCOME_BLACKJACK
    } outcome_t;

    // round sequencer states
    typedef enum logic [2:0] {
        ST_BET,
        ST_DEAL,
        ST_PLAYER,
        ST_DEALER,
        ST_RESULT
    } game_state_t;

endpackage

/* verilog/card_source.sv */
`timescale 1ns/1ps

`include "blackjack_consts.svh"

module card_source (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  draw,
    output blackjack_pkg::card_t  card
);

    // x^16 + x^14 + x^13 + x^11 + 1, right-shifting galois form
    localparam logic [`BJ_LFSR_W-1:0] tap_mask = 16'hB400;

    logic [`BJ_LFSR_W-1:0] lfsr;
    logic [`BJ_LFSR_W-1:0] lfsr_next;
    logic [3:0]            nibble;
    logic [3:0]            rank;

    // ----------------------------------------------------------------------
    // lfsr
    // ----------------------------------------------------------------------
    always_comb begin
        lfsr_next = {1'b0, lfsr[`BJ_LFSR_W-1:1]};
        if (lfsr[0]) begin
            lfsr_next = lfsr_next ^ tap_mask;
        end
    end

    // one step per consumed card
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            lfsr <= `BJ_LFSR_SEED;
        end else if (draw) begin
            lfsr <= lfsr_next;
        end
    end

    // ----------------------------------------------------------------------
    // rank mapping
    // ----------------------------------------------------------------------
    always_comb begin
        nibble = lfsr[3:0];
        // 13..15 wrap back onto ace..3
        if (nibble >= 4'd13) begin
            rank = nibble - 4'd13;
        end else begin
            rank = nibble;
        end
        rank = rank + 4'd1;
    end

    // jack, queen and king all count as ten
    always_comb begin
        if (rank > 4'd10) begin
            card = 4'd10;
        end else begin
            card = rank;
        end
    end

endmodule

/* verilog/hand_scorer.sv */
`timescale 1ns/1ps

`include "blackjack_consts.svh"

module hand_scorer (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   clear,
    input  logic                   take,
    input  blackjack_pkg::card_t   card,
    output blackjack_pkg::score_t  score,
    output logic [1:0]             card_count
);

    blackjack_pkg::score_t raw_sum;
    blackjack_pkg::score_t soft_sum;
    logic                  ace_seen;
    logic                  card_is_ace;

    assign card_is_ace = (card == blackjack_pkg::card_t'(1));

    // ----------------------------------------------------------------------
    // hand accumulation
    // ----------------------------------------------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            raw_sum  <= '0;
            ace_seen <= 1'b0;
        end else if (clear) begin
            raw_sum  <= '0;
            ace_seen <= 1'b0;
        end else if (take) begin
            raw_sum  <= raw_sum + blackjack_pkg::score_t'(card);
            ace_seen <= ace_seen | card_is_ace;
        end
    end

    // count stops at 3, only "exactly two" matters
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            card_count <= 2'd0;
        end else if (clear) begin
            card_count <= 2'd0;
        end else if (take && card_count != 2'd3) begin
            card_count <= card_count + 2'd1;
        end
    end

    // ----------------------------------------------------------------------
    // soft ace
    // ----------------------------------------------------------------------
    // at most one ace can ever count high
    assign soft_sum = raw_sum + `BJ_SCORE_W'(`BJ_ACE_BONUS);

    always_comb begin
        if (ace_seen && soft_sum <= `BJ_SCORE_W'(`BJ_TARGET)) begin
            score = soft_sum;
        end else begin
            score = raw_sum;
        end
    end

endmodule

/* verilog/coin_bank.sv */
`timescale 1ns/1ps

`include "blackjack_consts.svh"

module coin_bank (
    input  logic                     clk,
    input  logic                     reset,
    input  blackjack_pkg::bet_t      bet,
    input  logic                     round_start,
    input  logic                     result_valid,
    input  blackjack_pkg::outcome_t  outcome,
    output logic                     can_bet,
    output blackjack_pkg::coin_t     coins
);

    // one spare bit to catch the carry above the saturation limit
    localparam int sum_w = `BJ_COIN_W + 1;

    blackjack_pkg::bet_t  bet_q;
    logic [sum_w-1:0]     wide_bet;
    logic [sum_w-1:0]     payout;
    logic [sum_w-1:0]     sum;
    blackjack_pkg::coin_t settled;

    assign can_bet = (bet != '0) && (`BJ_COIN_W'(bet) <= coins);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            bet_q <= '0;
        end else if (round_start) begin
            bet_q <= bet;
        end
    end

    // ----------------------------------------------------------------------
    // payout
    // ----------------------------------------------------------------------
    assign wide_bet = sum_w'(bet_q);

    always_comb begin
        case (outcome)
            blackjack_pkg::OUTCOME_BLACKJACK: payout = wide_bet + (wide_bet << 1);
            blackjack_pkg::OUTCOME_WIN:       payout = wide_bet << 1;
            blackjack_pkg::OUTCOME_DRAW:      payout = wide_bet;
            default:                          payout = '0;
        endcase
    end

    assign sum = {1'b0, coins} + payout;

    always_comb begin
        if (sum > sum_w'(`BJ_MAX_COINS)) begin
            settled = `BJ_COIN_W'(`BJ_MAX_COINS);
        end else begin
            settled = sum[`BJ_COIN_W-1:0];
        end
    end

    // bet leaves the balance at round start and returns at settlement
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            coins <= `BJ_COIN_W'(`BJ_INITIAL_COINS);
        end else if (round_start) begin
            coins <= coins - `BJ_COIN_W'(bet);
        end else if (result_valid) begin
            coins <= settled;
        end
    end

endmodule

/* verilog/game_fsm.sv */
`timescale 1ns/1ps

`include "blackjack_consts.svh"

module game_fsm (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     next,
    input  logic                     hit,
    input  logic                     stand,
    input  logic                     can_bet,
    input  blackjack_pkg::score_t    player_score,
    input  blackjack_pkg::score_t    dealer_score,
    input  logic [1:0]               player_count,
    input  logic [1:0]               dealer_count,
    output logic                     draw,
    output logic                     player_take,
    output logic                     dealer_take,
    output logic                     clear,
    output logic                     round_start,
    output logic                     result_valid,
    output blackjack_pkg::outcome_t  outcome
);

    blackjack_pkg::game_state_t state;
    logic [1:0]                 deal_cnt;
    // card strobe pending in the current turn
    logic                       take_q;
    // player score check pending one cycle after a take
    logic                       settle_q;

    logic accept;
    logic player_bust;
    logic player_21;
    logic dealer_bust;
    logic dealer_21;
    logic dealer_low;
    logic player_natural;
    logic dealer_natural;

    // ----------------------------------------------------------------------
    // score decode
    // ----------------------------------------------------------------------
    assign player_bust    = player_score > `BJ_SCORE_W'(`BJ_TARGET);
    assign player_21      = player_score == `BJ_SCORE_W'(`BJ_TARGET);
    assign dealer_bust    = dealer_score > `BJ_SCORE_W'(`BJ_TARGET);
    assign dealer_21      = dealer_score == `BJ_SCORE_W'(`BJ_TARGET);
    assign dealer_low     = dealer_score < `BJ_SCORE_W'(`BJ_DEALER_STAND);
    assign player_natural = player_21 && (player_count == 2'd2);
    assign dealer_natural = dealer_21 && (dealer_count == 2'd2);

    // ----------------------------------------------------------------------
    // strobes
    // ----------------------------------------------------------------------
    assign accept      = (state == blackjack_pkg::ST_BET) && next && can_bet;
    assign clear       = accept;
    assign round_start = accept;

    // deal order is player, dealer, player, dealer
    assign player_take = ((state == blackjack_pkg::ST_DEAL) && !deal_cnt[0])
                       || ((state == blackjack_pkg::ST_PLAYER) && take_q);
    assign dealer_take = ((state == blackjack_pkg::ST_DEAL) && deal_cnt[0])
                       || ((state == blackjack_pkg::ST_DEALER) && take_q);
    assign draw        = player_take || dealer_take;

    assign result_valid = (state == blackjack_pkg::ST_RESULT);

    // ----------------------------------------------------------------------
    // sequencer
    // ----------------------------------------------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state    <= blackjack_pkg::ST_BET;
            deal_cnt <= 2'd0;
            take_q   <= 1'b0;
            settle_q <= 1'b0;
        end else begin
            case (state)
                blackjack_pkg::ST_BET: begin
                    if (accept) begin
                        state    <= blackjack_pkg::ST_DEAL;
                        deal_cnt <= 2'd0;
                    end
                end
                blackjack_pkg::ST_DEAL: begin
                    deal_cnt <= deal_cnt + 2'd1;
                    if (deal_cnt == 2'd3) begin
                        state    <= blackjack_pkg::ST_PLAYER;
                        settle_q <= 1'b1;
                    end
                end
                blackjack_pkg::ST_PLAYER: begin
                    if (take_q) begin
                        take_q   <= 1'b0;
                        settle_q <= 1'b1;
                    end else if (settle_q) begin
                        settle_q <= 1'b0;
                        // a natural on either side only shows right after the deal
                        if (player_natural || dealer_natural || player_bust) begin
                            state <= blackjack_pkg::ST_RESULT;
                        end else if (player_21) begin
                            state <= blackjack_pkg::ST_DEALER;
                        end
                    end else if (stand) begin
                        state <= blackjack_pkg::ST_DEALER;
                    end else if (hit) begin
                        take_q <= 1'b1;
                    end
                end
                blackjack_pkg::ST_DEALER: begin
                    // with take_q low the dealer score has settled
                    if (take_q) begin
                        take_q <= 1'b0;
                    end else if (dealer_low) begin
                        take_q <= 1'b1;
                    end else begin
                        state <= blackjack_pkg::ST_RESULT;
                    end
                end
                default: begin
                    state <= blackjack_pkg::ST_BET;
                end
            endcase
        end
    end

    // ----------------------------------------------------------------------
    // outcome is meaningful while result_valid is high
    // ----------------------------------------------------------------------
    always_comb begin
        if (player_bust) begin
            outcome = blackjack_pkg::OUTCOME_LOSE;
        end else if (player_natural && !dealer_natural) begin
            outcome = blackjack_pkg::OUTCOME_BLACKJACK;
        end else if (dealer_bust || player_score > dealer_score) begin
            outcome = blackjack_pkg::OUTCOME_WIN;
        end else if (player_score == dealer_score) begin
            outcome = blackjack_pkg::OUTCOME_DRAW;
        end else begin
            outcome = blackjack_pkg::OUTCOME_LOSE;
        end
    end

endmodule

/* verilog/blackjack.sv */
`timescale 1ns/1ps

module blackjack (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     next,
    input  logic                     hit,
    input  logic                     stand,
    input  blackjack_pkg::bet_t      bet,
    output blackjack_pkg::card_t     player_card,
    output blackjack_pkg::card_t     dealer_card,
    output logic                     player_card_valid,
    output logic                     dealer_card_valid,
    output blackjack_pkg::score_t    player_score,
    output blackjack_pkg::score_t    dealer_score,
    output blackjack_pkg::coin_t     coins,
    output blackjack_pkg::outcome_t  outcome,
    output logic                     result_valid
);

    blackjack_pkg::card_t card;
    logic                 draw;
    logic                 player_take;
    logic                 dealer_take;
    logic                 clear;
    logic                 round_start;
    logic                 can_bet;
    logic [1:0]           player_count;
    logic [1:0]           dealer_count;

    card_source u_card_source (
        .clk   (clk),
        .reset (reset),
        .draw  (draw),
        .card  (card)
    );

    hand_scorer u_player_hand (
        .clk        (clk),
        .reset      (reset),
        .clear      (clear),
        .take       (player_take),
        .card       (card),
        .score      (player_score),
        .card_count (player_count)
    );

    hand_scorer u_dealer_hand (
        .clk        (clk),
        .reset      (reset),
        .clear      (clear),
        .take       (dealer_take),
        .card       (card),
        .score      (dealer_score),
        .card_count (dealer_count)
    );

    coin_bank u_coin_bank (
        .clk          (clk),
        .reset        (reset),
        .bet          (bet),
        .round_start  (round_start),
        .result_valid (result_valid),
        .outcome      (outcome),
        .can_bet      (can_bet),
        .coins        (coins)
    );

    game_fsm u_game_fsm (
        .clk          (clk),
        .reset        (reset),
        .next         (next),
        .hit          (hit),
        .stand        (stand),
        .can_bet      (can_bet),
        .player_score (player_score),
        .dealer_score (dealer_score),
        .player_count (player_count),
        .dealer_count (dealer_count),
        .draw         (draw),
        .player_take  (player_take),
        .dealer_take  (dealer_take),
        .clear        (clear),
        .round_start  (round_start),
        .result_valid (result_valid),
        .outcome      (outcome)
    );

    // ----------------------------------------------------------------------
    // card output stage lines up with the scorer update
    // ----------------------------------------------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            player_card_valid <= 1'b0;
            dealer_card_valid <= 1'b0;
        end else begin
            player_card_valid <= player_take;
            dealer_card_valid <= dealer_take;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            player_card <= '0;
            dealer_card <= '0;
        end else begin
            if (player_take) begin
                player_card <= card;
            end
            if (dealer_take) begin
                dealer_card <= card;
            end
        end
    end

endmodule

/* verif/blackjack_tb.sv */
`timescale 1ns/1ps

`include "blackjack_consts.svh"

module blackjack_tb;

    localparam int clk_period = 40;
    localparam int num_rounds = 300;
    localparam int seed       = 69223;

    logic                    clk;
    logic                    reset;
    logic                    next;
    logic                    hit;
    logic                    stand;
    blackjack_pkg::bet_t     bet;
    blackjack_pkg::card_t    player_card;
    blackjack_pkg::card_t    dealer_card;
    logic                    player_card_valid;
    logic                    dealer_card_valid;
    blackjack_pkg::score_t   player_score;
    blackjack_pkg::score_t   dealer_score;
    blackjack_pkg::coin_t    coins;
    blackjack_pkg::outcome_t outcome;
    logic                    result_valid;

    // reference model of bank and hands
    int model_coins;
    int model_bet;
    int p_raw;
    int p_cnt;
    bit p_ace;
    int d_raw;
    int d_cnt;
    bit d_ace;

    // round tracking owned by the monitor
    bit in_round;
    int deal_cyc;
    bit dealer_turn;
    bit decision_due;
    int hit_due;
    int cyc;
    bit monitor_on;
    int rounds_played;
    int refills;

    blackjack u_blackjack (
        .clk               (clk),
        .reset             (reset),
        .next              (next),
        .hit               (hit),
        .stand             (stand),
        .bet               (bet),
        .player_card       (player_card),
        .dealer_card       (dealer_card),
        .player_card_valid (player_card_valid),
        .dealer_card_valid (dealer_card_valid),
        .player_score      (player_score),
        .dealer_score      (dealer_score),
        .coins             (coins),
        .outcome           (outcome),
        .result_valid      (result_valid)
    );

    initial begin
        clk = 1'b0;
    end

    always #(clk_period / 2) clk = ~clk;

    // ----------------------------------------------------------------------
    // model rules
    // ----------------------------------------------------------------------
    function automatic int soft_score(int raw, bit ace);
        if (ace && raw + `BJ_ACE_BONUS <= `BJ_TARGET) begin
            return raw + `BJ_ACE_BONUS;
        end
        return raw;
    endfunction

    function automatic blackjack_pkg::outcome_t rule_outcome();
        int ps;
        int ds;
        bit p_nat;
        bit d_nat;
        ps    = soft_score(p_raw, p_ace);
        ds    = soft_score(d_raw, d_ace);
        p_nat = (ps == `BJ_TARGET) && (p_cnt == 2);
        d_nat = (ds == `BJ_TARGET) && (d_cnt == 2);
        if (ps > `BJ_TARGET) begin
            return blackjack_pkg::OUTCOME_LOSE;
        end else if (p_nat && !d_nat) begin
            return blackjack_pkg::OUTCOME_BLACKJACK;
        end else if (ds > `BJ_TARGET || ps > ds) begin
            return blackjack_pkg::OUTCOME_WIN;
        end else if (ps == ds) begin
            return blackjack_pkg::OUTCOME_DRAW;
        end
        return blackjack_pkg::OUTCOME_LOSE;
    endfunction

    function automatic int settle(int balance, blackjack_pkg::outcome_t res, int stake);
        int total;
        case (res)
            blackjack_pkg::OUTCOME_BLACKJACK: total = balance + 3 * stake;
            blackjack_pkg::OUTCOME_WIN:       total = balance + 2 * stake;
            blackjack_pkg::OUTCOME_DRAW:      total = balance + stake;
            default:                          total = balance;
        endcase
        if (total > `BJ_MAX_COINS) begin
            total = `BJ_MAX_COINS;
        end
        return total;
    endfunction

    // ----------------------------------------------------------------------
    // checks
    // ----------------------------------------------------------------------
    task automatic fail_now(string msg);
        $display("%s", msg);
        $display("TESTS FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_card(string name, blackjack_pkg::card_t value);
        if (value < 1 || value > 10) begin
            fail_now($sformatf("ERROR %s outside 1 to 10, actual 0x%h", name, value));
        end
    endtask

    task automatic check_score(string name, blackjack_pkg::score_t expected,
                               blackjack_pkg::score_t actual);
        if (actual !== expected) begin
            fail_now($sformatf("ERROR %s expected 0x%h actual 0x%h", name, expected, actual));
        end
    endtask

    task automatic check_coins(blackjack_pkg::coin_t expected, blackjack_pkg::coin_t actual);
        if (actual !== expected) begin
            fail_now($sformatf("ERROR coins expected 0x%h actual 0x%h", expected, actual));
        end
    endtask

    task automatic check_outcome(blackjack_pkg::outcome_t expected,
                                 blackjack_pkg::outcome_t actual);
        if (actual !== expected) begin
            fail_now($sformatf("ERROR outcome expected 0x%h actual 0x%h", expected, actual));
        end
    endtask

    // ----------------------------------------------------------------------
    // monitor sampling at the falling edge
    // ----------------------------------------------------------------------
    task automatic reset_model();
        model_coins  = `BJ_INITIAL_COINS;
        model_bet    = 0;
        p_raw        = 0;
        p_cnt        = 0;
        p_ace        = 1'b0;
        d_raw        = 0;
        d_cnt        = 0;
        d_ace        = 1'b0;
        in_round     = 1'b0;
        deal_cyc     = 0;
        dealer_turn  = 1'b0;
        decision_due = 1'b0;
        hit_due      = -1;
    endtask

    task automatic open_round();
        reset_model_hands();
        model_coins = model_coins - int'(bet);
        model_bet   = int'(bet);
        in_round    = 1'b1;
    endtask

    task automatic reset_model_hands();
        p_raw        = 0;
        p_cnt        = 0;
        p_ace        = 1'b0;
        d_raw        = 0;
        d_cnt        = 0;
        d_ace        = 1'b0;
        deal_cyc     = 0;
        dealer_turn  = 1'b0;
        decision_due = 1'b0;
        hit_due      = -1;
    endtask

    // slots 2 and 4 carry player cards, 3 and 5 dealer cards
    task automatic check_deal_slot();
        bit want_p;
        bit want_d;
        want_p = (deal_cyc == 2) || (deal_cyc == 4);
        want_d = (deal_cyc == 3) || (deal_cyc == 5);
        if (player_card_valid !== want_p || dealer_card_valid !== want_d) begin
            fail_now($sformatf("deal order broken in cycle %0d of the round", deal_cyc));
        end
    endtask

    task automatic take_player_card();
        int ps;
        check_card("player_card", player_card);
        if (deal_cyc > 5) begin
            if (hit_due != cyc) begin
                fail_now("player card arrived without a hit two cycles before");
            end
            hit_due = -1;
        end
        p_raw = p_raw + int'(player_card);
        p_ace = p_ace | (player_card == 1);
        p_cnt = p_cnt + 1;
        ps    = soft_score(p_raw, p_ace);
        if (deal_cyc > 5) begin
            if (ps < `BJ_TARGET) begin
                decision_due = 1'b1;
            end else if (ps == `BJ_TARGET) begin
                dealer_turn = 1'b1;
            end
        end
    endtask

    task automatic take_dealer_card();
        check_card("dealer_card", dealer_card);
        if (deal_cyc > 5) begin
            if (!dealer_turn) begin
                fail_now("dealer card drawn outside the dealer turn");
            end
            if (soft_score(d_raw, d_ace) >= `BJ_DEALER_STAND) begin
                fail_now("dealer drew a card while already at 17 or more");
            end
        end
        d_raw = d_raw + int'(dealer_card);
        d_ace = d_ace | (dealer_card == 1);
        d_cnt = d_cnt + 1;
        // a 21 on either side at the end of the deal skips the player turn
        if (deal_cyc == 5 && soft_score(p_raw, p_ace) != `BJ_TARGET
                && soft_score(d_raw, d_ace) != `BJ_TARGET) begin
            decision_due = 1'b1;
        end
    endtask

    task automatic close_round();
        blackjack_pkg::outcome_t expected;
        int ps;
        int ds;
        bit p_nat;
        bit d_nat;
        expected = rule_outcome();
        ps       = soft_score(p_raw, p_ace);
        ds       = soft_score(d_raw, d_ace);
        p_nat    = (ps == `BJ_TARGET) && (p_cnt == 2);
        d_nat    = (ds == `BJ_TARGET) && (d_cnt == 2);
        if (deal_cyc <= 5) begin
            fail_now("result arrived before the deal finished");
        end
        if (hit_due != -1) begin
            fail_now("round ended with a hit still waiting for its card");
        end
        if (ps < `BJ_TARGET && !p_nat && !d_nat && !dealer_turn) begin
            fail_now("round ended during the player turn");
        end
        if (ps <= `BJ_TARGET && !p_nat && ds < `BJ_DEALER_STAND) begin
            fail_now("dealer stopped drawing below 17");
        end
        check_outcome(expected, outcome);
        model_coins   = settle(model_coins, expected, model_bet);
        in_round      = 1'b0;
        rounds_played = rounds_played + 1;
    endtask

    task automatic observe_cycle();
        cyc = cyc + 1;
        if (in_round) begin
            deal_cyc = deal_cyc + 1;
        end
        if (player_card_valid === 1'b1 && dealer_card_valid === 1'b1) begin
            fail_now("player and dealer cards strobed in the same cycle");
        end
        if (!in_round && (player_card_valid !== 1'b0 || dealer_card_valid !== 1'b0
                || result_valid !== 1'b0)) begin
            fail_now("card or result strobe seen outside a round");
        end
        if (in_round && deal_cyc <= 5) begin
            check_deal_slot();
        end
        if (player_card_valid) begin
            take_player_card();
        end
        if (dealer_card_valid) begin
            take_dealer_card();
        end
        check_score("player_score", blackjack_pkg::score_t'(soft_score(p_raw, p_ace)),
                    player_score);
        check_score("dealer_score", blackjack_pkg::score_t'(soft_score(d_raw, d_ace)),
                    dealer_score);
        check_coins(blackjack_pkg::coin_t'(model_coins), coins);
        if (result_valid) begin
            close_round();
        end else if (in_round) begin
            if (hit) begin
                hit_due = cyc + 2;
            end
            if (stand) begin
                dealer_turn = 1'b1;
            end
        end else if (next && bet != '0 && int'(bet) <= model_coins) begin
            open_round();
        end
    endtask

    always @(negedge clk) begin
        if (monitor_on) begin
            observe_cycle();
        end
    end

    // ----------------------------------------------------------------------
    // stimulus
    // ----------------------------------------------------------------------
    task automatic wait_drive_slot();
        @(posedge clk);
        #2;
    endtask

    task automatic apply_reset();
        monitor_on = 1'b0;
        reset      = 1'b1;
        next       = 1'b0;
        hit        = 1'b0;
        stand      = 1'b0;
        repeat (16) @(posedge clk);
        #2;
        reset = 1'b0;
        reset_model();
        monitor_on = 1'b1;
    endtask

    // basic strategy with some noise so that busts still happen
    function automatic bit want_hit();
        int ps;
        int ds;
        ps = soft_score(p_raw, p_ace);
        ds = soft_score(d_raw, d_ace);
        // a dealer at 17 or more draws nothing, so only beating it matters
        if (ds >= `BJ_DEALER_STAND && ds <= `BJ_TARGET) begin
            return ps < ds;
        end
        if (ps <= 11) begin
            return 1'b1;
        end
        if (ps >= `BJ_DEALER_STAND) begin
            return ($urandom % 16) == 0;
        end
        return $urandom % 2;
    endfunction

    task automatic play_round();
        int pick;
        int cap;
        int stake;
        pick = $urandom % 8;
        cap  = (model_coins < 15) ? model_coins : 15;
        if (pick == 0) begin
            stake = 0;
        end else if (pick == 1 && model_coins < 15) begin
            stake = model_coins + 1 + ($urandom % (15 - model_coins));
        end else if (pick < 5) begin
            stake = cap;
        end else begin
            stake = 1 + ($urandom % cap);
        end
        wait_drive_slot();
        next = 1'b1;
        bet  = blackjack_pkg::bet_t'(stake);
        wait_drive_slot();
        next = 1'b0;
        // bet is latched at accept and may change afterwards
        bet  = blackjack_pkg::bet_t'($urandom);
        while (in_round) begin
            hit   = 1'b0;
            stand = 1'b0;
            if (decision_due) begin
                decision_due = 1'b0;
                if (want_hit()) begin
                    hit = 1'b1;
                end else begin
                    stand = 1'b1;
                end
            end
            wait_drive_slot();
        end
        hit   = 1'b0;
        stand = 1'b0;
        repeat (2) wait_drive_slot();
    endtask

    initial begin
        void'($urandom(seed));
        reset         = 1'b1;
        next          = 1'b0;
        hit           = 1'b0;
        stand         = 1'b0;
        bet           = '0;
        monitor_on    = 1'b0;
        cyc           = 0;
        rounds_played = 0;
        refills       = 0;
        apply_reset();
        repeat (4) wait_drive_slot();
        for (int r = 0; r < num_rounds; r++) begin
            // an empty bank can never bet again
            if (model_coins == 0) begin
                refills = refills + 1;
                apply_reset();
            end
            play_round();
        end
        repeat (4) wait_drive_slot();
        $display("rounds settled %0d, bank refills %0d", rounds_played, refills);
        $display("TESTS PASSED");
        $finish;
    end

    // watchdog
    initial begin
        #(num_rounds * 200 * clk_period);
        fail_now("game stalled, the rounds did not finish in the allowed time");
    end

endmodule

/* blackjack.f */
+incdir+verilog
verilog/blackjack_pkg.sv
verilog/card_source.sv
verilog/hand_scorer.sv
verilog/coin_bank.sv
verilog/game_fsm.sv
verilog/blackjack.sv
verif/blackjack_tb.sv

/* Bender.yml */
package:
  name: blackjack

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/blackjack_pkg.sv
      - verilog/card_source.sv
      - verilog/hand_scorer.sv
      - verilog/coin_bank.sv
      - verilog/game_fsm.sv
      - verilog/blackjack.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - verif/blackjack_tb.sv
